/* hw/lsab_pkg.sv */
`default_nettype none

package lsab_pkg;

  // ------------------------------
  // Channels and sections
  // ------------------------------
  localparam int NUM_CH = 4;   // One section per channel
  localparam int SEC_W = 2;    // Section number

  // ------------------------------
  // Channel word fields
  // ------------------------------
  localparam int DATA_W = 32;  // Device data word
  localparam int ANC_W = 25;   // Ancillary word

  // ------------------------------
  // Section storage
  // ------------------------------
  localparam int DEPTH = 16;   // Entries per section
  localparam int PTR_W = 4;    // Wraps at DEPTH
  localparam int CNT_W = 5;    // Holds 0 to DEPTH

  // ------------------------------
  // Block mover command
  // ------------------------------
  localparam int ADDR_W = 9;   // Collection address
  localparam int COUNT_W = 6;  // Words per transfer

endpackage

`default_nettype wire

/* hw/lsab_wr_if.sv */
`default_nettype none

interface lsab_wr_if;

  logic [lsab_pkg::NUM_CH-1:0]                     wr;    // Store pulse per section
  logic [lsab_pkg::NUM_CH-1:0][lsab_pkg::DATA_W-1:0] data;
  logic [lsab_pkg::NUM_CH-1:0][lsab_pkg::ANC_W-1:0]  anc;
  logic [lsab_pkg::NUM_CH-1:0]                     intr;
  logic [lsab_pkg::NUM_CH-1:0]                     full;  // From the store

  modport producer (
    output wr,
    output data,
    output anc,
    output intr,
    input  full
  );

  modport store (
    input  wr,
    input  data,
    input  anc,
    input  intr,
    output full
  );

endinterface

`default_nettype wire

/* hw/lsab_rd_if.sv */
`default_nettype none

interface lsab_rd_if;

  logic [lsab_pkg::SEC_W-1:0]  sel;        // Section being drained
  logic                        pop;        // Remove head of sel
  logic [lsab_pkg::NUM_CH-1:0] empty;
  logic [lsab_pkg::DATA_W-1:0] head_data;  // Head of sel, combinational
  logic [lsab_pkg::ANC_W-1:0]  head_anc;
  logic                        head_intr;

  modport mover (
    output sel,
    output pop,
    input  empty,
    input  head_data,
    input  head_anc,
    input  head_intr
  );

  modport store (
    input  sel,
    input  pop,
    output empty,
    output head_data,
    output head_anc,
    output head_intr
  );

endinterface

`default_nettype wire

/* hw/channel_intake.sv */
`default_nettype none

module channel_intake (
  input  logic                                            CLK_n,
  input  logic                                            RST_MASTER,
  input  logic [lsab_pkg::NUM_CH-1:0]                     i_wr,
  input  logic [lsab_pkg::NUM_CH-1:0][lsab_pkg::DATA_W-1:0] i_data,
  input  logic [lsab_pkg::NUM_CH-1:0][lsab_pkg::ANC_W-1:0]  i_anc,
  input  logic [lsab_pkg::NUM_CH-1:0]                     i_intr,
  output logic [lsab_pkg::NUM_CH-1:0]                     o_overflow,
  lsab_wr_if.producer                                     wr_port
);

  logic [lsab_pkg::NUM_CH-1:0] wr_q;  // Registered channel strobes

  // ------------------------------
  // Strobes and overflow flags
  // ------------------------------
  always_ff @(posedge CLK_n)
  begin
    if (RST_MASTER)
    begin
      wr_q       <= '0;
      o_overflow <= '0;
    end
    else
    begin
      wr_q       <= i_wr;
      o_overflow <= o_overflow | (wr_q & wr_port.full);  // Sticky until reset
    end
  end

  // ------------------------------
  // Write fields
  // ------------------------------
  always_ff @(posedge CLK_n)
  begin
    wr_port.data <= i_data;
    wr_port.anc  <= i_anc;
    wr_port.intr <= i_intr;
  end

  // A write that meets a full section is dropped here
  assign wr_port.wr = wr_q & ~wr_port.full;

endmodule

`default_nettype wire

/* hw/lsab_sections.sv */
`default_nettype none

module lsab_sections (
  input  logic      CLK_n,
  input  logic      RST_MASTER,
  lsab_wr_if.store  wr_port,
  lsab_rd_if.store  rd_port
);

  logic [lsab_pkg::DATA_W-1:0] mem_data [lsab_pkg::NUM_CH][lsab_pkg::DEPTH];
  logic [lsab_pkg::ANC_W-1:0]  mem_anc  [lsab_pkg::NUM_CH][lsab_pkg::DEPTH];
  logic                        mem_intr [lsab_pkg::NUM_CH][lsab_pkg::DEPTH];

  logic [lsab_pkg::NUM_CH-1:0][lsab_pkg::PTR_W-1:0] wr_ptr;
  logic [lsab_pkg::NUM_CH-1:0][lsab_pkg::PTR_W-1:0] rd_ptr;
  logic [lsab_pkg::NUM_CH-1:0][lsab_pkg::CNT_W-1:0] count;  // Occupancy
  logic [lsab_pkg::NUM_CH-1:0]                     pop_sec;

  // ------------------------------
  // Status and pop decode
  // ------------------------------
  always_comb
  begin
    for (int s = 0; s < lsab_pkg::NUM_CH; s++)
    begin
      pop_sec[s]       = rd_port.pop && (rd_port.sel == s[lsab_pkg::SEC_W-1:0]);
      wr_port.full[s]  = count[s][lsab_pkg::PTR_W];  // Count reached DEPTH
      rd_port.empty[s] = (count[s] == '0);
    end
  end

  // ------------------------------
  // Entry storage
  // ------------------------------
  always_ff @(posedge CLK_n)
  begin
    for (int s = 0; s < lsab_pkg::NUM_CH; s++)
    begin
      if (wr_port.wr[s])
      begin
        mem_data[s][wr_ptr[s]] <= wr_port.data[s];
        mem_anc[s][wr_ptr[s]]  <= wr_port.anc[s];
        mem_intr[s][wr_ptr[s]] <= wr_port.intr[s];
      end
    end
  end

  // ------------------------------
  // Pointers and counts
  // ------------------------------
  always_ff @(posedge CLK_n)
  begin
    if (RST_MASTER)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      for (int s = 0; s < lsab_pkg::NUM_CH; s++)
      begin
        if (wr_port.wr[s])
          wr_ptr[s] <= wr_ptr[s] + 1'b1;  // Wraps at DEPTH
        if (pop_sec[s])
          rd_ptr[s] <= rd_ptr[s] + 1'b1;
        if (wr_port.wr[s] && !pop_sec[s])
          count[s] <= count[s] + 1'b1;
        else if (!wr_port.wr[s] && pop_sec[s])
          count[s] <= count[s] - 1'b1;
      end
    end
  end

  // Head of the section the mover has selected
  assign rd_port.head_data = mem_data[rd_port.sel][rd_ptr[rd_port.sel]];
  assign rd_port.head_anc  = mem_anc[rd_port.sel][rd_ptr[rd_port.sel]];
  assign rd_port.head_intr = mem_intr[rd_port.sel][rd_ptr[rd_port.sel]];

  // ------------------------------
  // Checks against the intake and the mover
  // ------------------------------
  a_no_store_full: assert property (@(posedge CLK_n) disable iff (RST_MASTER)
    (wr_port.wr & wr_port.full) == '0)
    else $error("store into a full section");

  a_no_pop_empty: assert property (@(posedge CLK_n) disable iff (RST_MASTER)
    !(rd_port.pop && rd_port.empty[rd_port.sel]))
    else $error("pop from an empty section");

endmodule

`default_nettype wire

/* hw/block_mover.sv */
`default_nettype none

module block_mover (
  input  logic                         CLK_n,
  input  logic                         RST_MASTER,
  input  logic                         i_issue,
  input  logic [lsab_pkg::SEC_W-1:0]   i_section,
  input  logic [lsab_pkg::ADDR_W-1:0]  i_start_addr,
  input  logic [lsab_pkg::COUNT_W-1:0] i_count_req,
  lsab_rd_if.mover                     rd_port,
  output logic                         o_mem_wr,
  output logic [lsab_pkg::ADDR_W-1:0]  o_mem_addr,
  output logic [lsab_pkg::DATA_W-1:0]  o_mem_data,
  output logic [lsab_pkg::COUNT_W-1:0] o_count_sent,
  output logic                         o_busy,
  output logic                         o_done,
  output logic                         o_irq,
  output logic [lsab_pkg::ANC_W-1:0]   o_ancill
);

  logic                         running;   // Run state
  logic                         ending;    // Last word sent, end pulse next
  logic                         end_irq;   // Ending on an interrupt word
  logic [lsab_pkg::ADDR_W-1:0]  start_q;
  logic [lsab_pkg::COUNT_W-1:0] count_q;
  logic [lsab_pkg::COUNT_W-1:0] sent_q;
  logic [lsab_pkg::COUNT_W-1:0] sent_next;
  logic [lsab_pkg::ADDR_W-1:0]  addr_off;
  logic                         accept;

  assign accept    = i_issue && !running;  // Ignored while busy
  assign sent_next = sent_q + 1'b1;
  assign addr_off  = {{(lsab_pkg::ADDR_W - lsab_pkg::COUNT_W){1'b0}}, sent_q};

  // One word per cycle while the section has data
  assign rd_port.pop = running && !ending && !rd_port.empty[rd_port.sel];

  assign o_busy       = running;
  assign o_count_sent = sent_q;

  // ------------------------------
  // Control FSM
  // ------------------------------
  always_ff @(posedge CLK_n)
  begin
    if (RST_MASTER)
    begin
      running     <= 1'b0;
      ending      <= 1'b0;
      end_irq     <= 1'b0;
      sent_q      <= '0;
      rd_port.sel <= '0;
      o_mem_wr    <= 1'b0;
      o_done      <= 1'b0;
      o_irq       <= 1'b0;
    end
    else
    begin
      o_mem_wr <= rd_port.pop;
      o_done   <= 1'b0;
      o_irq    <= 1'b0;
      if (accept)
      begin
        rd_port.sel <= i_section;
        sent_q      <= '0;
        end_irq     <= 1'b0;
        if (i_count_req == '0)
          o_done <= 1'b1;  // Nothing to move
        else
          running <= 1'b1;
      end
      else if (running && ending)
      begin
        running <= 1'b0;
        ending  <= 1'b0;
        o_irq   <= end_irq;
        o_done  <= !end_irq;
      end
      else if (rd_port.pop)
      begin
        sent_q <= sent_next;
        if (rd_port.head_intr)
        begin
          ending  <= 1'b1;
          end_irq <= 1'b1;
        end
        else if (sent_next == count_q)
          ending <= 1'b1;
      end
    end
  end

  // ------------------------------
  // Command and memory write fields
  // ------------------------------
  always_ff @(posedge CLK_n)
  begin
    if (accept)
    begin
      start_q <= i_start_addr;
      count_q <= i_count_req;
    end
    if (rd_port.pop)
    begin
      o_mem_addr <= start_q + addr_off;  // Wraps in ADDR_W
      o_mem_data <= rd_port.head_data;
      if (rd_port.head_intr)
        o_ancill <= rd_port.head_anc;
    end
  end

  a_end_exclusive: assert property (@(posedge CLK_n) disable iff (RST_MASTER)
    !(o_done && o_irq))
    else $error("done and irq together");

  a_wr_while_busy: assert property (@(posedge CLK_n) disable iff (RST_MASTER)
    o_mem_wr |-> o_busy)
    else $error("memory write while idle");

endmodule

`default_nettype wire

/* hw/lsab_mover_top.sv */
`default_nettype none

module lsab_mover_top (
  input  logic                                            CLK_n,
  input  logic                                            RST_MASTER,
  // ------------------------------
  input  logic [lsab_pkg::NUM_CH-1:0]                     i_wr,
  input  logic [lsab_pkg::NUM_CH-1:0][lsab_pkg::DATA_W-1:0] i_data,
  input  logic [lsab_pkg::NUM_CH-1:0][lsab_pkg::ANC_W-1:0]  i_anc,
  input  logic [lsab_pkg::NUM_CH-1:0]                     i_intr,
  output logic [lsab_pkg::NUM_CH-1:0]                     o_overflow,
  // ------------------------------
  input  logic                                            i_issue,
  input  logic [lsab_pkg::SEC_W-1:0]                      i_section,
  input  logic [lsab_pkg::ADDR_W-1:0]                     i_start_addr,
  input  logic [lsab_pkg::COUNT_W-1:0]                    i_count_req,
  output logic                                            o_mem_wr,
  output logic [lsab_pkg::ADDR_W-1:0]                     o_mem_addr,
  output logic [lsab_pkg::DATA_W-1:0]                     o_mem_data,
  output logic [lsab_pkg::COUNT_W-1:0]                    o_count_sent,
  output logic                                            o_busy,
  output logic                                            o_done,
  output logic                                            o_irq,
  output logic [lsab_pkg::ANC_W-1:0]                      o_ancill
);

  lsab_wr_if u_wr_if ();
  lsab_rd_if u_rd_if ();

  channel_intake u_intake (
    .CLK_n      (CLK_n),
    .RST_MASTER (RST_MASTER),
    .i_wr       (i_wr),
    .i_data     (i_data),
    .i_anc      (i_anc),
    .i_intr     (i_intr),
    .o_overflow (o_overflow),
    .wr_port    (u_wr_if.producer)
  );

  lsab_sections u_sections (
    .CLK_n      (CLK_n),
    .RST_MASTER (RST_MASTER),
    .wr_port    (u_wr_if.store),
    .rd_port    (u_rd_if.store)
  );

  block_mover u_mover (
    .CLK_n        (CLK_n),
    .RST_MASTER   (RST_MASTER),
    .i_issue      (i_issue),
    .i_section    (i_section),
    .i_start_addr (i_start_addr),
    .i_count_req  (i_count_req),
    .rd_port      (u_rd_if.mover),
    .o_mem_wr     (o_mem_wr),
    .o_mem_addr   (o_mem_addr),
    .o_mem_data   (o_mem_data),
    .o_count_sent (o_count_sent),
    .o_busy       (o_busy),
    .o_done       (o_done),
    .o_irq        (o_irq),
    .o_ancill     (o_ancill)
  );

endmodule

`default_nettype wire

/* sim/tb_lsab_mover.sv */
`default_nettype none

module tb_lsab_mover;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int END_NONE = 0;
  localparam int END_DONE = 1;
  localparam int END_IRQ = 2;

  logic                                             CLK_n;
  logic                                             RST_MASTER;
  logic [lsab_pkg::NUM_CH-1:0]                      i_wr;
  logic [lsab_pkg::NUM_CH-1:0][lsab_pkg::DATA_W-1:0] i_data;
  logic [lsab_pkg::NUM_CH-1:0][lsab_pkg::ANC_W-1:0]  i_anc;
  logic [lsab_pkg::NUM_CH-1:0]                      i_intr;
  logic [lsab_pkg::NUM_CH-1:0]                      o_overflow;
  logic                                             i_issue;
  logic [lsab_pkg::SEC_W-1:0]                       i_section;
  logic [lsab_pkg::ADDR_W-1:0]                      i_start_addr;
  logic [lsab_pkg::COUNT_W-1:0]                     i_count_req;
  logic                                             o_mem_wr;
  logic [lsab_pkg::ADDR_W-1:0]                      o_mem_addr;
  logic [lsab_pkg::DATA_W-1:0]                      o_mem_data;
  logic [lsab_pkg::COUNT_W-1:0]                     o_count_sent;
  logic                                             o_busy;
  logic                                             o_done;
  logic                                             o_irq;
  logic [lsab_pkg::ANC_W-1:0]                       o_ancill;

  logic [31:0] lfsr_state = 32'h4b52_e313;
  logic [57:0] model_q [lsab_pkg::NUM_CH][$];  // {intr, anc, data} per channel
  logic [lsab_pkg::NUM_CH-1:0] model_ovf;
  logic xfer_open;  // Model transfer in progress
  int act_sec;
  int act_start;
  int act_count;
  int act_sent;
  int exp_end;
  logic [lsab_pkg::ANC_W-1:0] exp_anc;
  int words_seen;
  int ends_seen;

  lsab_mover_top u_dut (.*);

  always #50 CLK_n = ~CLK_n;

  // ------------------------------
  // Failure reporting
  // ------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
      fail_run($sformatf("error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  // ------------------------------
  // Random source and reference
  // ------------------------------
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b)
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  // Outcome after a word leaves the section
  function automatic int ref_step(input int sent_after, input int count_req, input logic intr);
    if (intr)
      return END_IRQ;
    if (sent_after == count_req)
      return END_DONE;
    return END_NONE;
  endfunction

  function automatic logic [lsab_pkg::ADDR_W-1:0] ref_addr(input int start, input int sent);
    int a;
    a = (start + sent) % (1 << lsab_pkg::ADDR_W);
    return a[lsab_pkg::ADDR_W-1:0];
  endfunction

  // ------------------------------
  // Compare process
  // ------------------------------
  always @(negedge CLK_n)
  begin : compare
    logic [57:0] w;
    if (!RST_MASTER)
    begin
      if (o_mem_wr)
      begin
        if (!xfer_open || model_q[act_sec].size() == 0 || exp_end != END_NONE)
          fail_run($sformatf("error at %0d ns: memory write with no word expected", $time));
        w = model_q[act_sec].pop_front();
        check_val("mem addr", 64'(o_mem_addr), 64'(ref_addr(act_start, act_sent)));
        check_val("mem data", 64'(o_mem_data), 64'(w[31:0]));
        act_sent++;
        exp_end = ref_step(act_sent, act_count, w[57]);
        if (w[57])
          exp_anc = w[56:32];
        words_seen++;
      end
      if (o_done || o_irq)
      begin
        check_val("done", 64'(o_done), 64'(exp_end == END_DONE));
        check_val("irq", 64'(o_irq), 64'(exp_end == END_IRQ));
        check_val("count sent", 64'(o_count_sent), 64'(act_sent));
        if (o_irq)
          check_val("ancillary", 64'(o_ancill), 64'(exp_anc));
        exp_end = END_NONE;
        xfer_open = 1'b0;
        ends_seen++;
      end
    end
  end

  // ------------------------------
  // Stimulus tasks
  // ------------------------------
  task automatic chan_write(input int ch, input logic intr);
    logic [31:0] d;
    logic [24:0] a;
    d = rand_bits(32);
    a = 25'(rand_bits(25));
    i_wr[ch]   = 1'b1;
    i_data[ch] = d;
    i_anc[ch]  = a;
    i_intr[ch] = intr;
    if (model_q[ch].size() < lsab_pkg::DEPTH)
      model_q[ch].push_back({intr, a, d});
    else
      model_ovf[ch] = 1'b1;  // Dropped by the intake
    @(negedge CLK_n);
    i_wr[ch]   = 1'b0;
    i_intr[ch] = 1'b0;
  endtask

  task automatic issue(input int sec, input int start, input int cnt);
    if (!xfer_open)  // Otherwise the mover ignores it
    begin
      act_sec   = sec;
      act_start = start;
      act_count = cnt;
      act_sent  = 0;
      exp_end   = (cnt == 0) ? END_DONE : END_NONE;
      xfer_open = (cnt != 0);
    end
    i_issue      = 1'b1;
    i_section    = sec[1:0];
    i_start_addr = start[8:0];
    i_count_req  = cnt[5:0];
    @(negedge CLK_n);
    i_issue = 1'b0;
  endtask

  task automatic wait_end(input int prev);
    int n;
    n = 0;
    while (ends_seen == prev)
    begin
      @(negedge CLK_n);
      n++;
      if (n > 300)
        fail_run("timed out waiting for the end of a transfer");
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge CLK_n);
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  initial
  begin
    int e;
    int w;
    int n;
    CLK_n = 1'b0;
    RST_MASTER = 1'b1;
    i_wr = '0;
    i_data = '0;
    i_anc = '0;
    i_intr = '0;
    i_issue = 1'b0;
    i_section = '0;
    i_start_addr = '0;
    i_count_req = '0;
    model_ovf = '0;
    xfer_open = 1'b0;
    act_sec = 0;
    act_start = 0;
    act_count = 0;
    act_sent = 0;
    exp_end = END_NONE;
    exp_anc = '0;
    words_seen = 0;
    ends_seen = 0;
    repeat (2) @(posedge CLK_n);
    @(negedge CLK_n);
    RST_MASTER = 1'b0;
    check_val("busy after reset", 64'(o_busy), 64'd0);
    check_val("overflow after reset", 64'(o_overflow), 64'd0);

    // Burst with address wrap
    repeat (10) chan_write(2, 1'b0);
    e = ends_seen;
    issue(2, 'h1FC, 8);
    wait_end(e);
    check_val("words in burst", 64'(act_sent), 64'd8);

    // Early end on an interrupt word
    for (int i = 0; i < 6; i++)
      chan_write(1, i == 3);
    e = ends_seen;
    issue(1, 'h040, 20);
    wait_end(e);
    check_val("words before irq", 64'(act_sent), 64'd4);
    e = ends_seen;
    issue(1, 'h080, 2);
    wait_end(e);

    // Stall on an empty section
    e = ends_seen;
    issue(0, 'h100, 5);
    for (int i = 0; i < 5; i++)
    begin
      idle(rand_bits(3));
      chan_write(0, 1'b0);
    end
    wait_end(e);

    // Overflow, then a transfer one word short
    repeat (17) chan_write(3, 1'b0);
    idle(3);
    check_val("overflow", 64'(o_overflow), 64'h8);
    e = ends_seen;
    w = words_seen;
    issue(3, 'h010, 17);
    n = 0;
    while (words_seen < w + 17 && n < 80)
    begin
      @(negedge CLK_n);
      n++;
    end
    check_val("words before stall", 64'(words_seen - w), 64'd16);
    check_val("busy in stall", 64'(o_busy), 64'd1);
    chan_write(3, 1'b0);  // Fresh word completes it
    wait_end(e);

    // Ignored issue, traffic on other channels, empty transfer
    e = ends_seen;
    issue(1, 'h1F0, 4);
    issue(0, 'h000, 3);
    for (int i = 0; i < 4; i++)
    begin
      chan_write(1, 1'b0);
      chan_write(0, 1'b0);
      chan_write(2, 1'b0);
    end
    wait_end(e);
    e = ends_seen;
    issue(0, 'h020, 4);
    wait_end(e);
    e = ends_seen;
    issue(2, 'h030, 6);
    wait_end(e);
    e = ends_seen;
    w = words_seen;
    issue(3, 'h050, 0);
    wait_end(e);
    idle(4);
    check_val("writes on zero count", 64'(words_seen - w), 64'd0);
    check_val("overflow at end", 64'(o_overflow), 64'(model_ovf));
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hw/lsab_pkg.sv
hw/lsab_wr_if.sv
hw/lsab_rd_if.sv
hw/channel_intake.sv
hw/lsab_sections.sv
hw/block_mover.sv
hw/lsab_mover_top.sv
sim/tb_lsab_mover.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the block mover testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing \
  --top-module tb_lsab_mover \
  -f src.f \
  -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "build failed"
  exit $status
fi

./obj_dir/Vtb_lsab_mover
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0
